// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int XLEN   = 32;
    localparam int TAG_W  = 4;
    localparam int REG_W  = 5;
    localparam int STRB_W = XLEN / 8;    // One strobe bit per byte lane
    localparam int OFF_W  = 2;           // Byte offset within a word

    //////////////////////////////
    // Memory operations
    //////////////////////////////

    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_e;

    //////////////////////////////
    // Structs
    //////////////////////////////

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        mem_op_e           op;
        logic [REG_W-1:0]  rd;
        logic [XLEN-1:0]   rs1;
        logic [XLEN-1:0]   rs2;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   result;
        logic              taken;    // Branch outcome from execute
    } uop_t;

    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
        logic              we;
    } l1_req_t;

    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;     // Already shifted into its lanes
        logic [STRB_W-1:0] wstrb;
        logic [OFF_W-1:0]  offset;
    } lane_t;

    function automatic logic is_load(input mem_op_e op);
        return (op == LB) || (op == LH) || (op == LW) || (op == LBU) || (op == LHU);
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

`default_nettype wire

// File: hdl/mem_addr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_addr_unit (
    input  wire mem_pkg::uop_t  uop_i,
    output mem_pkg::lane_t      lane_o
);

    import mem_pkg::*;

    logic [XLEN-1:0]   addr;
    logic [OFF_W-1:0]  offset;
    logic [STRB_W-1:0] wstrb;
    logic [XLEN-1:0]   data_low;
    logic [XLEN-1:0]   wdata;

    //////////////////////////////
    // Effective address
    //////////////////////////////

    assign addr   = uop_i.rs1 + uop_i.imm;
    assign offset = addr[OFF_W-1:0];

    //////////////////////////////
    // Store lanes
    //////////////////////////////

    // Size mask on rs2 first, then strobe and data move together
    always_comb begin
        case (uop_i.op)
            SB: begin
                wstrb    = 4'b0001 << offset;
                data_low = {{(XLEN-8){1'b0}}, uop_i.rs2[7:0]};
            end
            SH: begin
                wstrb    = 4'b0011 << offset;
                data_low = {{(XLEN-16){1'b0}}, uop_i.rs2[15:0]};
            end
            SW: begin
                wstrb    = 4'b1111;                  // Offset is zero when aligned
                data_low = uop_i.rs2;
            end
            default: begin
                wstrb    = '0;                       // Loads write nothing
                data_low = '0;
            end
        endcase
    end

    assign wdata = data_low << {offset, 3'b000};      // Byte offset to bit shift

    assign lane_o = '{
        addr:   addr,
        wdata:  wdata,
        wstrb:  wstrb,
        offset: offset
    };

endmodule

`default_nettype wire

// File: hdl/mem_req_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_req_ctrl (
    input  wire                 clk_i,
    input  wire                 rstn_i,

    input  wire mem_pkg::uop_t  exe_uop_i,
    input  wire mem_pkg::lane_t lane_i,

    input  wire                 l1_req_ready_i,
    input  wire                 l1_rsp_valid_i,

    output mem_pkg::uop_t       held_uop_o,
    output mem_pkg::l1_req_t    l1_req_o,
    output logic                l1_req_valid_o,
    output logic                l1_rsp_ready_o,
    output logic                stall_o,
    output logic                mem_done_o,
    output logic                pass_o
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RSP
    } state_e;

    state_e state_q;
    state_e state_d;
    uop_t   uop_q;
    logic   accept;
    logic   is_mem_op;

    //////////////////////////////
    // Acceptance
    //////////////////////////////

    assign accept    = exe_uop_i.valid && (state_q == IDLE);   // Stall is low only in IDLE
    assign is_mem_op = is_load(exe_uop_i.op) || is_store(exe_uop_i.op);

    always_ff @(posedge clk_i) begin
        if (accept) begin
            uop_q <= exe_uop_i;
        end
    end

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept && is_mem_op) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (l1_req_ready_i) begin
                    state_d = RSP;                     // Request taken by L1
                end
            end
            RSP: begin
                if (l1_rsp_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    // In IDLE the incoming uop goes straight on, so pass-through costs one register
    assign held_uop_o = (state_q == IDLE) ? exe_uop_i : uop_q;

    assign l1_req_o = '{
        addr:  lane_i.addr,
        wdata: lane_i.wdata,
        wstrb: lane_i.wstrb,
        we:    is_store(uop_q.op)
    };

    assign l1_req_valid_o = (state_q == REQ);
    assign l1_rsp_ready_o = (state_q == RSP);
    assign stall_o        = (state_q != IDLE);
    assign mem_done_o     = (state_q == RSP) && l1_rsp_valid_i;   // Response transfer
    assign pass_o         = accept && !is_mem_op;

endmodule

`default_nettype wire

// File: hdl/load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align (
    input  wire                          clk_i,
    input  wire                          rstn_i,

    input  wire mem_pkg::uop_t           held_uop_i,
    input  wire [mem_pkg::OFF_W-1:0]     offset_i,
    input  wire [mem_pkg::XLEN-1:0]      rsp_data_i,
    input  wire                          mem_done_i,
    input  wire                          pass_i,

    output mem_pkg::uop_t                wb_uop_o
);

    import mem_pkg::*;

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] load_val;
    uop_t            wb_d;
    uop_t            wb_q;

    //////////////////////////////
    // Load extraction
    //////////////////////////////

    assign shifted = rsp_data_i >> {offset_i, 3'b000};    // Addressed byte to bit 0

    always_comb begin
        case (held_uop_i.op)
            LB:      load_val = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     load_val = {{(XLEN-8){1'b0}}, shifted[7:0]};
            LH:      load_val = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     load_val = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: load_val = shifted;                    // LW
        endcase
    end

    //////////////////////////////
    // Writeback register
    //////////////////////////////

    always_comb begin
        wb_d       = held_uop_i;
        wb_d.valid = 1'b0;
        if (pass_i) begin
            wb_d.valid = 1'b1;
        end else if (mem_done_i) begin
            wb_d.valid = 1'b1;
            if (is_load(held_uop_i.op)) begin
                wb_d.result = load_val;                     // Stores keep result
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wb_q <= wb_d;
        if (!rstn_i) begin
            wb_q.valid <= 1'b0;
        end
    end

    assign wb_uop_o = wb_q;

endmodule

`default_nettype wire

// File: hdl/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                      clk_i,
    input  wire                      rstn_i,

    // Pipeline side
    input  wire mem_pkg::uop_t       exe_uop_i,
    output wire                      stall_o,
    output wire mem_pkg::uop_t       wb_uop_o,

    // L1 request channel
    output wire mem_pkg::l1_req_t    l1_req_o,
    output wire                      l1_req_valid_o,
    input  wire                      l1_req_ready_i,

    // L1 response channel
    input  wire [mem_pkg::XLEN-1:0]  l1_rsp_data_i,
    input  wire                      l1_rsp_valid_i,
    output wire                      l1_rsp_ready_o
);

    import mem_pkg::*;

    uop_t  held_uop;
    lane_t lane;
    logic  mem_done;
    logic  pass;

    //////////////////////////////
    // Capture and request issue
    //////////////////////////////

    mem_req_ctrl u_req_ctrl (
        .clk_i          ( clk_i          ),
        .rstn_i         ( rstn_i         ),
        .exe_uop_i      ( exe_uop_i      ),
        .lane_i         ( lane           ),
        .l1_req_ready_i ( l1_req_ready_i ),
        .l1_rsp_valid_i ( l1_rsp_valid_i ),
        .held_uop_o     ( held_uop       ),
        .l1_req_o       ( l1_req_o       ),
        .l1_req_valid_o ( l1_req_valid_o ),
        .l1_rsp_ready_o ( l1_rsp_ready_o ),
        .stall_o        ( stall_o        ),
        .mem_done_o     ( mem_done       ),
        .pass_o         ( pass           )
    );

    //////////////////////////////
    // Address and lanes
    //////////////////////////////

    mem_addr_unit u_addr_unit (
        .uop_i  ( held_uop ),
        .lane_o ( lane     )
    );

    //////////////////////////////
    // Load alignment
    //////////////////////////////

    load_align u_load_align (
        .clk_i      ( clk_i         ),
        .rstn_i     ( rstn_i        ),
        .held_uop_i ( held_uop      ),
        .offset_i   ( lane.offset   ),    // Same held uop as the request
        .rsp_data_i ( l1_rsp_data_i ),
        .mem_done_i ( mem_done      ),
        .pass_i     ( pass          ),
        .wb_uop_o   ( wb_uop_o      )
    );

endmodule

`default_nettype wire

// File: verif/mem_stage_assert.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_assert (
    input wire                   clk_i,
    input wire                   rstn_i,
    input wire mem_pkg::uop_t    exe_uop_i,
    input wire                   stall_o,
    input wire mem_pkg::uop_t    wb_uop_o,
    input wire mem_pkg::l1_req_t l1_req_o,
    input wire                   l1_req_valid_o,
    input wire                   l1_req_ready_i,
    input wire                   l1_rsp_valid_i,
    input wire                   l1_rsp_ready_o
);

    import mem_pkg::*;

    int fail_count = 0;    // Read by the testbench at the end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |=> !stall_o && !l1_req_valid_o && !l1_rsp_ready_o && !wb_uop_o.valid)
    else begin
        fail_count = fail_count + 1;
        $error("Outputs not low after a reset cycle");
    end

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l1_req_valid_o && !l1_req_ready_i |=> l1_req_valid_o && $stable(l1_req_o))
    else begin
        fail_count = fail_count + 1;
        $error("L1 request dropped or changed before ready");
    end

    // Stall holds from issue until the response transfer
    a_stall_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
        stall_o && !(l1_rsp_valid_i && l1_rsp_ready_o) |=> stall_o)
    else begin
        fail_count = fail_count + 1;
        $error("Stall dropped while a memory access was pending");
    end

    a_rsp_to_wb: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l1_rsp_valid_i && l1_rsp_ready_o |=> wb_uop_o.valid && !stall_o)
    else begin
        fail_count = fail_count + 1;
        $error("No writeback one cycle after the L1 response");
    end

    // Non-memory uops flow every cycle
    a_pass_flow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        exe_uop_i.valid && !stall_o && exe_uop_i.op == NONE |=> wb_uop_o.valid && !stall_o)
    else begin
        fail_count = fail_count + 1;
        $error("Non-memory uop did not pass in one cycle");
    end

    a_mem_issue: assert property (@(posedge clk_i) disable iff (!rstn_i)
        exe_uop_i.valid && !stall_o && exe_uop_i.op != NONE |=> stall_o && l1_req_valid_o)
    else begin
        fail_count = fail_count + 1;
        $error("Memory uop did not raise stall and request");
    end

endmodule

bind mem_stage mem_stage_assert u_assert (
    .clk_i          ( clk_i          ),
    .rstn_i         ( rstn_i         ),
    .exe_uop_i      ( exe_uop_i      ),
    .stall_o        ( stall_o        ),
    .wb_uop_o       ( wb_uop_o       ),
    .l1_req_o       ( l1_req_o       ),
    .l1_req_valid_o ( l1_req_valid_o ),
    .l1_req_ready_i ( l1_req_ready_i ),
    .l1_rsp_valid_i ( l1_rsp_valid_i ),
    .l1_rsp_ready_o ( l1_rsp_ready_o )
);

`default_nettype wire

// File: verif/tb_mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage;

    import mem_pkg::*;

    localparam int          N_OPS       = 200;
    localparam int          CLK_PERIOD  = 40;
    localparam int          WATCHDOG_NS = (N_OPS * 40 + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'h04961b08;

    logic            clk_i;
    logic            rstn_i;
    uop_t            exe_uop_i;
    logic            stall_o;
    uop_t            wb_uop_o;
    l1_req_t         l1_req_o;
    logic            l1_req_valid_o;
    logic            l1_req_ready_i;
    logic [XLEN-1:0] l1_rsp_data_i;
    logic            l1_rsp_valid_i;
    logic            l1_rsp_ready_o;

    logic [XLEN-1:0] l1_mem [256];
    logic [XLEN-1:0] ref_mem [256];
    uop_t            exp_wb_q [$];
    l1_req_t         exp_req_q [$];
    logic [31:0]     stim_rng;
    logic [31:0]     l1_rng;
    int              wb_errors;
    int              req_errors;
    int              mem_errors;

    mem_stage u_dut (
        .clk_i          ( clk_i          ),
        .rstn_i         ( rstn_i         ),
        .exe_uop_i      ( exe_uop_i      ),
        .stall_o        ( stall_o        ),
        .wb_uop_o       ( wb_uop_o       ),
        .l1_req_o       ( l1_req_o       ),
        .l1_req_valid_o ( l1_req_valid_o ),
        .l1_req_ready_i ( l1_req_ready_i ),
        .l1_rsp_data_i  ( l1_rsp_data_i  ),
        .l1_rsp_valid_i ( l1_rsp_valid_i ),
        .l1_rsp_ready_o ( l1_rsp_ready_o )
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a ^ 8'h3c, ~a, a, a ^ 8'ha5};
    endfunction

    function automatic int access_bytes(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    // Picks bytes from the stored word, then extends
    function automatic logic [XLEN-1:0] load_value(input mem_op_e op,
                                                   input logic [XLEN-1:0] word, input int off);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = word[8*off +: 8];
        b1 = (off < 3) ? word[8*(off+1) +: 8] : 8'h00;
        case (op)
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'h000000, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'h0000, b1, b0};
            default: return word;
        endcase
    endfunction

    //////////////////////////////
    // Stimulus and reference
    //////////////////////////////

    task automatic issue_op(input logic force_none);
        uop_t            u;
        uop_t            wb;
        l1_req_t         req;
        logic [XLEN-1:0] addr;
        logic            accepted;
        int              sel;
        int              size;
        int              off;
        int              idx;
        stim_rng = xorshift32(stim_rng);
        sel      = force_none ? 0 : int'(stim_rng[31:28]) % 9;
        u        = '0;
        u.valid  = 1'b1;
        u.op     = mem_op_e'(sel[3:0]);
        u.tag    = stim_rng[3:0];
        u.rd     = stim_rng[8:4];
        u.taken  = stim_rng[9];
        size     = access_bytes(u.op);
        off      = int'(stim_rng[17:16]) & ~(size - 1);       // Natural alignment
        addr     = {24'h000000, stim_rng[25:20], 2'b00} + off;  // 64 words in use
        stim_rng = xorshift32(stim_rng);
        u.rs2    = stim_rng;
        stim_rng = xorshift32(stim_rng);
        u.result = stim_rng;
        u.imm    = {{26{stim_rng[5]}}, stim_rng[5:0]};
        u.rs1    = addr - u.imm;
        idx      = int'(addr[9:2]);
        wb       = u;
        req      = '0;
        req.addr = addr;
        if (u.op inside {SB, SH, SW}) begin
            req.we = 1'b1;
            for (int k = 0; k < size; k++) begin
                req.wstrb[off + k]          = 1'b1;
                req.wdata[8*(off+k) +: 8]   = u.rs2[8*k +: 8];
                ref_mem[idx][8*(off+k) +: 8] = u.rs2[8*k +: 8];
            end
            exp_req_q.push_back(req);
        end else if (u.op != NONE) begin
            wb.result = load_value(u.op, ref_mem[idx], off);
            exp_req_q.push_back(req);
        end
        exp_wb_q.push_back(wb);
        exe_uop_i = u;
        accepted  = 1'b0;
        while (!accepted) begin                            // Held while stalled
            @(negedge clk_i);
            accepted = !stall_o;
            @(posedge clk_i);
            #1;
        end
        exe_uop_i.valid = 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin : stimulus
        int total;
        mem_errors = 0;
        stim_rng   = SEED;
        rstn_i     = 1'b0;
        exe_uop_i  = '0;
        for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i);
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            issue_op(n < 4);                               // Opening burst of pass-through
            stim_rng = xorshift32(stim_rng);
            if (stim_rng[2:0] == 3'b000) begin
                @(posedge clk_i);
                #1;
            end
        end
        while (exp_wb_q.size() != 0) @(posedge clk_i);
        repeat (2) @(posedge clk_i);
        for (int i = 0; i < 256; i++) begin
            assert (l1_mem[i] == ref_mem[i])
            else begin
                $display("[ERROR] %0t: memory word %0d holds %08h, expected %08h",
                         $time, i, l1_mem[i], ref_mem[i]);
                mem_errors++;
            end
        end
        total = wb_errors + req_errors + mem_errors + u_dut.u_assert.fail_count;
        $display("Errors: writeback %0d, request %0d, memory %0d, assertion %0d",
                 wb_errors, req_errors, mem_errors, u_dut.u_assert.fail_count);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    //////////////////////////////
    // L1 memory model
    //////////////////////////////

    initial begin : l1_model
        logic            req_fire;
        logic            rsp_fire;
        logic            pending;
        l1_req_t         got;
        l1_req_t         want;
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] rsp_word;
        req_errors     = 0;
        l1_req_ready_i = 1'b0;
        l1_rsp_valid_i = 1'b0;
        l1_rsp_data_i  = '0;
        l1_rng         = SEED ^ 32'h9e3779b9;
        pending        = 1'b0;
        rsp_word       = '0;
        for (int i = 0; i < 256; i++) l1_mem[i] = fill_word(i);
        forever begin
            @(negedge clk_i);
            req_fire = l1_req_valid_o && l1_req_ready_i;
            rsp_fire = l1_rsp_valid_i && l1_rsp_ready_o;
            got      = l1_req_o;
            @(posedge clk_i);
            #1;
            if (rsp_fire) pending = 1'b0;
            if (req_fire && exp_req_q.size() == 0) begin
                $display("L1 request at %0t arrived with no memory access issued", $time);
                req_errors++;
            end else if (req_fire) begin
                want = exp_req_q.pop_front();
                for (int k = 0; k < 4; k++) mask[8*k +: 8] = {8{want.wstrb[k]}};
                assert (got.addr == want.addr && got.we == want.we && (!want.we ||
                        (got.wstrb == want.wstrb && (got.wdata & mask) == want.wdata)))
                else begin
                    $display("[ERROR] %0t: request %h %b %b %h, expected %h %b %b %h",
                             $time, got.addr, got.we, got.wstrb, got.wdata,
                             want.addr, want.we, want.wstrb, want.wdata);
                    req_errors++;
                end
                for (int k = 0; k < 4; k++) begin
                    if (got.we && got.wstrb[k]) begin
                        l1_mem[got.addr[9:2]][8*k +: 8] = got.wdata[8*k +: 8];
                    end
                end
                rsp_word = l1_mem[got.addr[9:2]];
                pending  = 1'b1;
            end
            l1_rng         = xorshift32(l1_rng);
            l1_req_ready_i = !pending && (l1_rng[1:0] != 2'b00);   // Random back-pressure
            l1_rsp_valid_i = pending && (l1_rng[3:2] != 2'b00);
            l1_rsp_data_i  = pending ? rsp_word : l1_rng;
        end
    end

    //////////////////////////////
    // Writeback checks
    //////////////////////////////

    initial begin : wb_checker
        uop_t want;
        wb_errors = 0;
        forever begin
            @(negedge clk_i);
            if (wb_uop_o.valid === 1'b1 && exp_wb_q.size() == 0) begin
                $display("Writeback of tag %0h at %0t with no uop outstanding",
                         wb_uop_o.tag, $time);
                wb_errors++;
            end else if (wb_uop_o.valid === 1'b1) begin
                want = exp_wb_q.pop_front();
                assert (wb_uop_o == want)
                else begin
                    $display("[ERROR] %0t: wb tag %h op %0d rd %0d res %h, want %h %0d %0d %h",
                             $time, wb_uop_o.tag, wb_uop_o.op, wb_uop_o.rd, wb_uop_o.result,
                             want.tag, want.op, want.rd, want.result);
                    wb_errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/mem_pkg.sv
hdl/mem_addr_unit.sv
hdl/mem_req_ctrl.sv
hdl/load_align.sv
hdl/mem_stage.sv
verif/mem_stage_assert.sv
verif/tb_mem_stage.sv

// File: Makefile
# Verilator build of the memory stage testbench

TOP := tb_mem_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f build.f

# The simulation log decides pass or fail
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
